// File: source/core_pkg.sv
package core_pkg;

    typedef logic [63:0] xlen_t;      // Data word or byte address
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_t;

    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;

    // Next PC source, sequential, branch or jump
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP} pc_sel_t;

    typedef enum logic [2:0] {ST_FETCH, ST_EXECUTE, ST_MEMORY, ST_WRITEBACK} core_state_t;

    typedef enum logic [2:0] {BUS_IDLE, BUS_AR, BUS_R, BUS_AW_W, BUS_B} bus_state_t;

    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;

    localparam xlen_t RESET_PC    = 64'h0;
    localparam xlen_t INSTR_BYTES = 64'd4;

endpackage

// File: source/mem_req_if.sv
`timescale 1ns/100ps

interface mem_req_if;
    import core_pkg::*;

    logic  req;      // Held until done
    logic  write;
    xlen_t addr;
    xlen_t wdata;
    xlen_t rdata;    // Valid in the done cycle
    logic  done;     // One-cycle pulse

    modport client (
        output req, write, addr, wdata,
        input  rdata, done
    );

    modport master (
        input  req, write, addr, wdata,
        output rdata, done
    );

endinterface

// File: source/alu.sv
`timescale 1ns/100ps

module alu (
    input  core_pkg::xlen_t   a,
    input  core_pkg::xlen_t   b,
    input  core_pkg::alu_op_t op,
    output core_pkg::xlen_t   result,
    output logic              equal
);
    import core_pkg::*;

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = '0;
        endcase
    end

    assign equal = (a == b);   // Branch decision for beq

endmodule

// File: source/reg_file.sv
`timescale 1ns/100ps

module reg_file (
    input  logic                clk,
    input  logic                reset,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    input  core_pkg::reg_addr_t rd,
    input  core_pkg::xlen_t     wdata,
    input  logic                we,
    output core_pkg::xlen_t     rs1_value,
    output core_pkg::xlen_t     rs2_value
);
    import core_pkg::*;

    xlen_t regs [32];

    // x0 is cleared by reset and never written
    assign rs1_value = regs[rs1];
    assign rs2_value = regs[rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/100ps

module instr_decoder (
    input  core_pkg::instr_t  instr,
    output core_pkg::alu_op_t alu_op,
    output logic              use_imm,
    output logic              use_pc,
    output core_pkg::wb_sel_t wb_sel,
    output core_pkg::pc_sel_t pc_sel,
    output logic              is_mem,
    output logic              is_store,
    output logic              reg_we_dec,
    output core_pkg::xlen_t   imm
);
    import core_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    alu_op_t    arith_op;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // Register and immediate forms share funct3, sub needs funct7 bit 5
    always_comb begin
        case (funct3)
            F3_XOR:  arith_op = ALU_XOR;
            F3_OR:   arith_op = ALU_OR;
            F3_AND:  arith_op = ALU_AND;
            default: arith_op = (opcode == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
        endcase
    end

    always_comb begin
        alu_op     = ALU_ADD;
        use_imm    = 1'b0;
        use_pc     = 1'b0;
        wb_sel     = WB_ALU;
        pc_sel     = PC_SEQ;
        is_mem     = 1'b0;
        is_store   = 1'b0;
        reg_we_dec = 1'b0;
        imm        = '0;
        case (opcode)
            OPC_OP_IMM: begin
                alu_op     = arith_op;
                use_imm    = 1'b1;
                reg_we_dec = 1'b1;
                imm        = imm_i;
            end
            OPC_OP: begin
                alu_op     = arith_op;
                reg_we_dec = 1'b1;
            end
            OPC_LOAD: begin
                use_imm    = 1'b1;
                is_mem     = 1'b1;
                wb_sel     = WB_MEM;
                reg_we_dec = 1'b1;
                imm        = imm_i;
            end
            OPC_STORE: begin
                use_imm  = 1'b1;
                is_mem   = 1'b1;
                is_store = 1'b1;
                imm      = imm_s;
            end
            OPC_BRANCH: begin
                imm = imm_b;            // Equality flag from rs1, rs2
                if (funct3 == F3_BEQ)
                    pc_sel = PC_BRANCH;
            end
            OPC_JAL: begin
                use_pc     = 1'b1;
                use_imm    = 1'b1;
                wb_sel     = WB_PC4;
                pc_sel     = PC_JUMP;
                reg_we_dec = 1'b1;
                imm        = imm_j;
            end
            default: ;                  // No-op, nothing written
        endcase
    end

endmodule

// File: source/core_control.sv
`timescale 1ns/100ps

module core_control (
    input  logic              clk,
    input  logic              reset,
    mem_req_if.client         fetch,
    mem_req_if.client         data,
    output core_pkg::instr_t  instr,
    output core_pkg::xlen_t   pc,
    input  logic              is_mem,
    input  logic              is_store,
    input  logic              reg_we_dec,
    input  core_pkg::pc_sel_t pc_sel,
    input  core_pkg::xlen_t   imm,
    input  core_pkg::xlen_t   alu_result,
    input  core_pkg::xlen_t   rs2_value,
    input  logic              branch_taken,
    output core_pkg::xlen_t   mem_rdata,
    output logic              reg_we
);
    import core_pkg::*;

    core_state_t state;
    xlen_t       pc_seq;
    xlen_t       pc_target;
    xlen_t       next_pc;

    assign pc_seq    = pc + INSTR_BYTES;
    assign pc_target = pc + imm;   // Branch target, ALU busy comparing

    always_comb begin
        case (pc_sel)
            PC_BRANCH: next_pc = branch_taken ? pc_target : pc_seq;
            PC_JUMP:   next_pc = alu_result;   // pc + imm for jal
            default:   next_pc = pc_seq;
        endcase
    end

    // Requests follow the phase, so they drop the cycle after done
    assign fetch.req   = (state == ST_FETCH);
    assign fetch.write = 1'b0;
    assign fetch.addr  = pc;
    assign fetch.wdata = '0;

    assign data.req    = (state == ST_MEMORY);
    assign data.write  = is_store;
    assign data.addr   = alu_result;   // rs1 + imm
    assign data.wdata  = rs2_value;

    assign reg_we = reg_we_dec && (state == ST_WRITEBACK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_FETCH;
            pc    <= RESET_PC;
        end else begin
            case (state)
                ST_FETCH:   if (fetch.done) state <= ST_EXECUTE;
                ST_EXECUTE: state <= is_mem ? ST_MEMORY : ST_WRITEBACK;
                ST_MEMORY:  if (data.done) state <= ST_WRITEBACK;
                ST_WRITEBACK: begin
                    state <= ST_FETCH;
                    pc    <= next_pc;
                end
                default:    state <= ST_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch.done)
            instr <= pc[2] ? fetch.rdata[63:32] : fetch.rdata[31:0];   // Word within doubleword
        if (data.done)
            mem_rdata <= data.rdata;
    end

    // Done only answers the request that is raised
    a_done_owner: assert property (@(posedge clk) disable iff (reset)
        (!fetch.done || fetch.req) && (!data.done || data.req));

    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        pc[1:0] == 2'b00);

endmodule

// File: source/axi_lite_master.sv
`timescale 1ns/100ps

module axi_lite_master (
    input  logic            clk,
    input  logic            reset,
    mem_req_if.master       fetch,
    mem_req_if.master       data,
    output core_pkg::xlen_t ar_addr,
    output logic            ar_valid,
    input  logic            ar_ready,
    input  core_pkg::xlen_t r_data,
    input  logic            r_valid,
    output logic            r_ready,
    output core_pkg::xlen_t aw_addr,
    output logic            aw_valid,
    input  logic            aw_ready,
    output core_pkg::xlen_t w_data,
    output logic            w_valid,
    input  logic            w_ready,
    input  logic            b_valid,
    output logic            b_ready
);
    import core_pkg::*;

    bus_state_t state;
    xlen_t      addr_q;
    xlen_t      wdata_q;
    logic       sel_data;     // Owner of the running transaction
    logic       aw_pend;
    logic       w_pend;
    logic       pick_data;
    logic       pick_write;
    logic       r_hs;
    logic       b_hs;

    assign pick_data  = !fetch.req;   // Fetch wins a tie
    assign pick_write = pick_data ? data.write : fetch.write;

    assign ar_addr  = addr_q;
    assign aw_addr  = addr_q;
    assign w_data   = wdata_q;
    assign ar_valid = (state == BUS_AR);
    assign r_ready  = (state == BUS_R);
    assign aw_valid = (state == BUS_AW_W) && aw_pend;
    assign w_valid  = (state == BUS_AW_W) && w_pend;
    assign b_ready  = (state == BUS_B);

    assign r_hs = r_ready && r_valid;
    assign b_hs = b_ready && b_valid;

    assign fetch.rdata = r_data;
    assign data.rdata  = r_data;
    assign fetch.done  = r_hs && !sel_data;
    assign data.done   = (r_hs || b_hs) && sel_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= BUS_IDLE;
            sel_data <= 1'b0;
            aw_pend  <= 1'b0;
            w_pend   <= 1'b0;
        end else begin
            case (state)
                BUS_IDLE: if (fetch.req || data.req) begin
                    sel_data <= pick_data;
                    aw_pend  <= pick_write;
                    w_pend   <= pick_write;
                    state    <= pick_write ? BUS_AW_W : BUS_AR;
                end
                BUS_AR: if (ar_ready) state <= BUS_R;
                BUS_R:  if (r_valid) state <= BUS_IDLE;
                BUS_AW_W: begin
                    // AW and W may complete in either order
                    if (aw_ready)
                        aw_pend <= 1'b0;
                    if (w_ready)
                        w_pend <= 1'b0;
                    if ((!aw_pend || aw_ready) && (!w_pend || w_ready))
                        state <= BUS_B;
                end
                BUS_B:   if (b_valid) state <= BUS_IDLE;
                default: state <= BUS_IDLE;
            endcase
        end
    end

    // Last idle cycle holds the accepted request
    always_ff @(posedge clk) begin
        if (state == BUS_IDLE) begin
            addr_q  <= pick_data ? data.addr : fetch.addr;
            wdata_q <= pick_data ? data.wdata : fetch.wdata;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr));

    a_aw_hold: assert property (@(posedge clk) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr));

    a_w_hold: assert property (@(posedge clk) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(w_data));

endmodule

// File: source/cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic            clk,
    input  logic            reset,
    output core_pkg::xlen_t ar_addr,
    output logic            ar_valid,
    input  logic            ar_ready,
    input  core_pkg::xlen_t r_data,
    input  logic            r_valid,
    output logic            r_ready,
    output core_pkg::xlen_t aw_addr,
    output logic            aw_valid,
    input  logic            aw_ready,
    output core_pkg::xlen_t w_data,
    output logic            w_valid,
    input  logic            w_ready,
    input  logic            b_valid,
    output logic            b_ready
);
    import core_pkg::*;

    instr_t  instr;
    xlen_t   pc;
    alu_op_t alu_op;
    logic    use_imm;
    logic    use_pc;
    wb_sel_t wb_sel;
    pc_sel_t pc_sel;
    logic    is_mem;
    logic    is_store;
    logic    reg_we_dec;
    logic    reg_we;
    xlen_t   imm;
    xlen_t   rs1_value;
    xlen_t   rs2_value;
    xlen_t   alu_a;
    xlen_t   alu_b;
    xlen_t   alu_result;
    logic    alu_equal;
    xlen_t   mem_rdata;
    xlen_t   wb_data;

    mem_req_if fetch_if ();
    mem_req_if data_if ();

    assign alu_a   = use_pc ? pc : rs1_value;
    assign alu_b   = use_imm ? imm : rs2_value;
    assign wb_data = (wb_sel == WB_MEM) ? mem_rdata :
                     (wb_sel == WB_PC4) ? pc + INSTR_BYTES : alu_result;   // Link for jal

    core_control i_core_control (
        .clk, .reset, .fetch(fetch_if), .data(data_if), .instr, .pc,
        .is_mem, .is_store, .reg_we_dec, .pc_sel, .imm, .alu_result, .rs2_value,
        .branch_taken(alu_equal), .mem_rdata, .reg_we
    );

    instr_decoder i_instr_decoder (
        .instr, .alu_op, .use_imm, .use_pc, .wb_sel, .pc_sel,
        .is_mem, .is_store, .reg_we_dec, .imm
    );

    reg_file i_reg_file (
        .clk, .reset, .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .wdata(wb_data), .we(reg_we), .rs1_value, .rs2_value
    );

    alu i_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result), .equal(alu_equal));

    axi_lite_master i_axi_lite_master (
        .clk, .reset, .fetch(fetch_if), .data(data_if),
        .ar_addr, .ar_valid, .ar_ready, .r_data, .r_valid, .r_ready,
        .aw_addr, .aw_valid, .aw_ready, .w_data, .w_valid, .w_ready,
        .b_valid, .b_ready
    );

endmodule

// File: dv/axi_mem_model.sv
`timescale 1ns/100ps

module axi_mem_model (
    input  logic            clk,
    input  logic            reset,
    input  core_pkg::xlen_t ar_addr,
    input  logic            ar_valid,
    output logic            ar_ready,
    output core_pkg::xlen_t r_data,
    output logic            r_valid,
    input  logic            r_ready,
    input  core_pkg::xlen_t aw_addr,
    input  logic            aw_valid,
    output logic            aw_ready,
    input  core_pkg::xlen_t w_data,
    input  logic            w_valid,
    output logic            w_ready,
    output logic            b_valid,
    input  logic            b_ready
);
    import core_pkg::*;

    localparam int WORDS    = 64;    // 512 bytes, program low and data from 0x100
    localparam int PROG_LEN = 28;

    xlen_t      mem [WORDS];
    instr_t     prog [PROG_LEN];
    logic [1:0] ar_wait;
    logic [1:0] r_wait;
    logic [1:0] aw_wait;
    logic [1:0] w_wait;
    logic [1:0] b_wait;
    xlen_t      rd_addr;
    logic       rd_pend;
    xlen_t      wr_addr;
    xlen_t      wr_data;
    logic       aw_got;
    logic       w_got;

    function automatic instr_t itype(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
                                     logic [2:0] f3, logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t rtype(logic [6:0] f7, logic [4:0] rd, logic [4:0] rs1,
                                     logic [4:0] rs2, logic [2:0] f3);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t stype(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], OPC_STORE};   // sd
    endfunction

    function automatic instr_t btype(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic instr_t jtype(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    initial begin
        void'($urandom(71));
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        aw_ready = 1'b0;
        w_ready  = 1'b0;
        b_valid  = 1'b0;
        prog[0]  = itype(OPC_OP_IMM, 5'd1, 5'd0, 3'b000, 12'h100);   // Data base
        prog[1]  = itype(OPC_OP_IMM, 5'd2, 5'd0, 3'b000, 12'd25);
        prog[2]  = itype(OPC_OP_IMM, 5'd3, 5'd0, 3'b000, 12'hFFA);   // -6
        prog[3]  = stype(5'd3, 5'd1, 12'd0);
        prog[4]  = rtype(7'h00, 5'd4, 5'd2, 5'd3, 3'b000);           // add
        prog[5]  = stype(5'd4, 5'd1, 12'd8);
        prog[6]  = rtype(7'h20, 5'd5, 5'd2, 5'd3, 3'b000);           // sub
        prog[7]  = stype(5'd5, 5'd1, 12'd16);
        prog[8]  = rtype(7'h00, 5'd6, 5'd2, 5'd3, F3_AND);
        prog[9]  = stype(5'd6, 5'd1, 12'd24);
        prog[10] = rtype(7'h00, 5'd7, 5'd2, 5'd3, F3_OR);
        prog[11] = stype(5'd7, 5'd1, 12'd32);
        prog[12] = rtype(7'h00, 5'd8, 5'd2, 5'd3, F3_XOR);
        prog[13] = stype(5'd8, 5'd1, 12'd40);
        prog[14] = stype(5'd2, 5'd1, 12'd48);
        prog[15] = itype(OPC_LOAD, 5'd9, 5'd1, 3'b011, 12'd48);      // ld back
        prog[16] = rtype(7'h00, 5'd10, 5'd9, 5'd2, 3'b000);
        prog[17] = stype(5'd10, 5'd1, 12'd56);
        prog[18] = btype(5'd2, 5'd2, 13'd8);                         // Taken
        prog[19] = stype(5'd2, 5'd1, 12'd248);                       // Poison
        prog[20] = btype(5'd2, 5'd3, 13'd8);                         // Not taken
        prog[21] = stype(5'd10, 5'd1, 12'd64);
        prog[22] = jtype(5'd12, 21'd8);
        prog[23] = stype(5'd2, 5'd1, 12'd248);                       // Poison
        prog[24] = stype(5'd12, 5'd1, 12'd72);                       // Link value
        prog[25] = itype(OPC_OP_IMM, 5'd13, 5'd0, 3'b000, 12'h5A5);
        prog[26] = stype(5'd13, 5'd1, 12'd80);                       // Done marker
        prog[27] = jtype(5'd0, 21'd0);                               // Park here
        for (int i = 0; i < WORDS; i++)
            mem[i] = {32'hFEED_0000, 32'(i * 8)};   // Low half is the byte address
        for (int i = 0; i < PROG_LEN; i++) begin
            if (i % 2 == 1)
                mem[i / 2][63:32] = prog[i];
            else
                mem[i / 2][31:0] = prog[i];
        end
    end

    always @(posedge clk) begin
        if (reset) begin
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            b_valid  <= 1'b0;
            rd_pend  <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            ar_wait  <= 2'($urandom);
            aw_wait  <= 2'($urandom);
            w_wait   <= 2'($urandom);
            b_wait   <= 2'($urandom);
        end else begin
            // Each ready rises after 0 to 3 cycles of valid
            if (ar_valid && ar_ready) begin
                ar_ready <= 1'b0;
                ar_wait  <= 2'($urandom);
                rd_addr  <= ar_addr;
                rd_pend  <= 1'b1;
                r_wait   <= 2'($urandom);
            end else if (ar_valid) begin
                if (ar_wait == 2'd0)
                    ar_ready <= 1'b1;
                else
                    ar_wait <= ar_wait - 2'd1;
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;
                rd_pend <= 1'b0;
            end else if (rd_pend && !r_valid) begin
                if (r_wait == 2'd0) begin
                    r_valid <= 1'b1;
                    r_data  <= mem[rd_addr[8:3]];   // Doubleword, low bits ignored
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
            if (aw_valid && aw_ready) begin
                aw_ready <= 1'b0;
                aw_wait  <= 2'($urandom);
                wr_addr  <= aw_addr;
                aw_got   <= 1'b1;
            end else if (aw_valid) begin
                if (aw_wait == 2'd0)
                    aw_ready <= 1'b1;
                else
                    aw_wait <= aw_wait - 2'd1;
            end
            if (w_valid && w_ready) begin
                w_ready <= 1'b0;
                w_wait  <= 2'($urandom);
                wr_data <= w_data;
                w_got   <= 1'b1;
            end else if (w_valid) begin
                if (w_wait == 2'd0)
                    w_ready <= 1'b1;
                else
                    w_wait <= w_wait - 2'd1;
            end
            // Response once both halves of the write are in
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end else if (aw_got && w_got) begin
                if (b_wait == 2'd0) begin
                    b_valid <= 1'b1;
                    mem[wr_addr[8:3]] <= wr_data;
                    aw_got  <= 1'b0;
                    w_got   <= 1'b0;
                    b_wait  <= 2'($urandom);
                end else begin
                    b_wait <= b_wait - 2'd1;
                end
            end
        end
    end

endmodule

// File: dv/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;
    import core_pkg::*;

    localparam int    CLK_PERIOD   = 10;
    localparam int    MAX_INSTR    = 400;
    localparam int    WORST_CYCLES = 32;    // Fetch and data transfer both fully stalled
    localparam int    NUM_STORES   = 11;
    localparam xlen_t BASE         = 64'h100;
    localparam xlen_t POISON       = 64'h1F8;
    localparam xlen_t OP_A         = 64'd25;
    localparam xlen_t OP_B         = 64'hFFFF_FFFF_FFFF_FFFA;   // -6

    logic  clk;
    logic  reset;
    xlen_t ar_addr;
    logic  ar_valid;
    logic  ar_ready;
    xlen_t r_data;
    logic  r_valid;
    logic  r_ready;
    xlen_t aw_addr;
    logic  aw_valid;
    logic  aw_ready;
    xlen_t w_data;
    logic  w_valid;
    logic  w_ready;
    logic  b_valid;
    logic  b_ready;

    int    reset_errors;
    int    protocol_errors;
    int    store_errors;
    int    write_count;
    int    read_count;
    logic  fetch_seen;
    logic  marker_seen;
    logic  prev_ar_valid;
    logic  prev_ar_ready;
    xlen_t prev_ar_addr;
    logic  prev_aw_valid;
    logic  prev_aw_ready;
    xlen_t prev_aw_addr;
    logic  prev_w_valid;
    logic  prev_w_ready;
    xlen_t prev_w_data;
    xlen_t got_addr;
    xlen_t got_data;
    xlen_t exp_addr [NUM_STORES];
    xlen_t exp_data [NUM_STORES];

    cpu_top i_cpu_top (.*);

    axi_mem_model i_axi_mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_counts();
        $display("Errors: reset %0d, protocol %0d, store %0d (writes seen %0d of %0d)",
                 reset_errors, protocol_errors, store_errors, write_count, NUM_STORES);
    endtask

    // A valid left waiting must stay up with the same payload
    task automatic check_hold(input string chan, input string field, input logic valid,
                              input xlen_t value, input xlen_t held);
        assert (valid) else begin
            protocol_errors++;
            $display("%s_valid dropped before %s_ready at %0t", chan, chan, $time);
        end
        assert (value == held) else begin
            protocol_errors++;
            $display("** Error: %s = %h, expected %h", field, value, held);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            if (!fetch_seen) begin
                assert (!aw_valid && !w_valid && !r_ready && !b_ready) else begin
                    reset_errors++;
                    $display("Bus output active before the first fetch at %0t", $time);
                end
                if (ar_valid) begin
                    fetch_seen <= 1'b1;
                    assert (ar_addr == RESET_PC) else begin
                        reset_errors++;
                        $display("** Error: ar_addr = %h, expected %h", ar_addr, RESET_PC);
                    end
                end
            end
            if (prev_ar_valid && !prev_ar_ready)
                check_hold("ar", "ar_addr", ar_valid, ar_addr, prev_ar_addr);
            if (prev_aw_valid && !prev_aw_ready)
                check_hold("aw", "aw_addr", aw_valid, aw_addr, prev_aw_addr);
            if (prev_w_valid && !prev_w_ready)
                check_hold("w", "w_data", w_valid, w_data, prev_w_data);
            if (ar_valid && ar_ready)
                read_count <= read_count + 1;
            if (aw_valid && aw_ready) begin
                got_addr <= aw_addr;
                assert (aw_addr != POISON) else begin
                    store_errors++;
                    $display("** Error: aw_addr = %h is the poison address", aw_addr);
                end
            end
            if (w_valid && w_ready)
                got_data <= w_data;
            if (b_valid && b_ready) begin
                write_count <= write_count + 1;
                assert (write_count < NUM_STORES) else begin
                    store_errors++;
                    $display("Write beyond the expected store table at %0t", $time);
                end
                if (write_count < NUM_STORES) begin
                    assert (got_addr == exp_addr[write_count]) else begin
                        store_errors++;
                        $display("** Error: aw_addr = %h, expected %h",
                                 got_addr, exp_addr[write_count]);
                    end
                    assert (got_data == exp_data[write_count]) else begin
                        store_errors++;
                        $display("** Error: w_data = %h, expected %h",
                                 got_data, exp_data[write_count]);
                    end
                    if (write_count == NUM_STORES - 1)
                        marker_seen <= 1'b1;
                end
            end
        end
        prev_ar_valid <= ar_valid;
        prev_ar_ready <= ar_ready;
        prev_ar_addr  <= ar_addr;
        prev_aw_valid <= aw_valid;
        prev_aw_ready <= aw_ready;
        prev_aw_addr  <= aw_addr;
        prev_w_valid  <= w_valid;
        prev_w_ready  <= w_ready;
        prev_w_data   <= w_data;
    end

    initial begin
        #(MAX_INSTR * WORST_CYCLES * CLK_PERIOD);
        $display("Timeout, done marker not written within %0d instructions", MAX_INSTR);
        $display("CHECKS FAILED");
        report_counts();
        $finish;
    end

    initial begin
        int marker_reads;
        reset           = 1'b1;
        reset_errors    = 0;
        protocol_errors = 0;
        store_errors    = 0;
        write_count     = 0;
        read_count      = 0;
        fetch_seen      = 1'b0;
        marker_seen     = 1'b0;
        for (int i = 0; i < NUM_STORES; i++)
            exp_addr[i] = BASE + 64'(8 * i);
        exp_data[0]  = OP_B;
        exp_data[1]  = OP_A + OP_B;
        exp_data[2]  = OP_A - OP_B;
        exp_data[3]  = OP_A & OP_B;
        exp_data[4]  = OP_A | OP_B;
        exp_data[5]  = OP_A ^ OP_B;
        exp_data[6]  = OP_A;
        exp_data[7]  = OP_A + OP_A;   // Loaded doubleword plus x2
        exp_data[8]  = OP_A + OP_A;   // Store after the untaken beq
        exp_data[9]  = 64'd92;        // jal link, its own address plus 4
        exp_data[10] = 64'h5A5;       // Done marker
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        wait (marker_seen);
        marker_reads = read_count;
        wait (read_count >= marker_reads + 2);   // Parked loop keeps fetching
        assert (write_count == NUM_STORES) else begin
            store_errors++;
            $display("** Error: write_count = %h, expected %h", write_count, NUM_STORES);
        end
        if (reset_errors + protocol_errors + store_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        report_counts();
        $finish;
    end

endmodule

// File: build.f
source/core_pkg.sv
source/mem_req_if.sv
source/alu.sv
source/reg_file.sv
source/instr_decoder.sv
source/core_control.sv
source/axi_lite_master.sv
source/cpu_top.sv
dv/axi_mem_model.sv
dv/tb_cpu.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_cpu -f build.f -o tb_cpu_sim \
    && ./obj_dir/tb_cpu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0
